/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - source/rv_isa_pkg.sv
      - source/core_pkg.sv
      - source/pc_reg.sv
      - source/inst_decoder.sv
      - source/register_file.sv
      - source/alu.sv
      - source/rv_core_top.sv
  - target: simulation
    files:
      - sim/retire_checker.sv
      - sim/tb_rv_core.sv

/* project.f */
source/rv_isa_pkg.sv
source/core_pkg.sv
source/pc_reg.sv
source/inst_decoder.sv
source/register_file.sv
source/alu.sv
source/rv_core_top.sv
sim/retire_checker.sv
sim/tb_rv_core.sv

/* sim/retire_checker.sv */
`timescale 1ns/1ps

module retire_checker (
  input  logic              clk,
  input  logic              reset,
  input  logic [31:0]       inst,
  input  logic [8*16-1:0]   test_name,
  input  core_pkg::retire_t retire,
  input  logic [31:0]       current_pc,
  input  logic [31:0]       next_pc,
  input  logic              halted,
  output int                error_count,
  output int                check_count
);

  // shadow architectural state
  logic [31:0] shadow [32];
  logic [31:0] exp_pc;
  logic        exp_halted;
  int          errors = 0;
  int          checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  // expected retire from the isa rules and the shadow registers
  function automatic core_pkg::retire_t ref_retire(
    input logic [31:0] word,
    input logic [31:0] pc,
    input logic        stopped
  );
    core_pkg::retire_t r;
    logic [31:0]       src_1;
    logic [31:0]       src_2;
    logic [31:0]       imm_i;
    logic [31:0]       imm_u;
    src_1 = shadow[word[19:15]];
    src_2 = shadow[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_u = {word[31:12], 12'h000};
    r = '0;
    r.valid = !stopped;
    r.pc = pc;
    r.rd = word[11:7];
    r.not_impl = 1'b1;
    case (word[6:0])
      rv_isa_pkg::opcode_op: begin
        if (word[14:12] == 3'b000 && word[31:25] == 7'b0000000) begin
          r.wdata = src_1 + src_2;
          r.wen = 1'b1;
        end else if (word[14:12] == 3'b000 && word[31:25] == rv_isa_pkg::funct7_sub) begin
          r.wdata = src_1 - src_2;
          r.wen = 1'b1;
        end
      end
      rv_isa_pkg::opcode_op_imm: begin
        // addi only, funct3 zero
        r.wdata = src_1 + imm_i;
        r.wen = (word[14:12] == 3'b000);
      end
      rv_isa_pkg::opcode_lui: begin
        r.wdata = imm_u;
        r.wen = 1'b1;
      end
      rv_isa_pkg::opcode_auipc: begin
        // pc of the retiring instruction
        r.wdata = pc + imm_u;
        r.wen = 1'b1;
      end
      rv_isa_pkg::opcode_system: begin
        r.is_ebreak = (word == rv_isa_pkg::inst_ebreak);
      end
      default: begin
      end
    endcase
    r.not_impl = !(r.wen || r.is_ebreak);
    // nothing written once stopped
    r.wen = r.wen && !stopped;
    return r;
  endfunction

  task automatic compare(input string field, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %0s %0s at %0t: expected %h, actual %h",
               test_name, field, $time, expected, actual);
    end
  endtask

  // compare on every rising edge, update shadow afterwards
  always @(posedge clk) begin
    core_pkg::retire_t exp_ret;
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        shadow[i] = '0;
      end
      exp_pc = rv_isa_pkg::reset_pc;
      exp_halted = 1'b0;
    end else begin
      exp_ret = ref_retire(inst, exp_pc, exp_halted);
      compare("current_pc", exp_pc, current_pc);
      compare("halted", 32'(exp_halted), 32'(halted));
      compare("valid", 32'(exp_ret.valid), 32'(retire.valid));
      compare("wen", 32'(exp_ret.wen), 32'(retire.wen));
      if (exp_ret.valid) begin
        compare("pc", exp_ret.pc, retire.pc);
        compare("not_impl", 32'(exp_ret.not_impl), 32'(retire.not_impl));
        compare("is_ebreak", 32'(exp_ret.is_ebreak), 32'(retire.is_ebreak));
        compare("next_pc", exp_ret.is_ebreak ? exp_pc : exp_pc + 32'd4, next_pc);
      end else begin
        // frozen while halted
        compare("next_pc", exp_pc, next_pc);
      end
      if (exp_ret.wen) begin
        compare("rd", 32'(exp_ret.rd), 32'(retire.rd));
        compare("wdata", exp_ret.wdata, retire.wdata);
        if (exp_ret.rd != 5'd0) begin
          shadow[exp_ret.rd] = exp_ret.wdata;
        end
      end
      if (exp_ret.valid && exp_ret.is_ebreak) begin
        exp_halted = 1'b1;
      end else if (exp_ret.valid) begin
        exp_pc = exp_pc + 32'd4;
      end
    end
  end

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int unsigned clk_period   = 40;
  localparam int unsigned reset_cycles = 3;
  // 4 reset adds, 40 imm, 40 reg, 16 bad, 1 ebreak, 6 after halt
  localparam int unsigned num_inst     = 107;

  logic              clk;
  logic              reset;
  logic [31:0]       inst;
  logic [31:0]       current_pc;
  logic [31:0]       next_pc;
  logic              halted;
  core_pkg::retire_t retire;
  logic [8*16-1:0]   test_name;
  int                error_count;
  int                check_count;
  logic [15:0]       lfsr_state = 16'd80;

  rv_core_top #(
    .xlen     (rv_isa_pkg::xlen),
    .reset_pc (rv_isa_pkg::reset_pc)
  ) rv_core_top_inst (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .current_pc (current_pc),
    .next_pc    (next_pc),
    .halted     (halted),
    .retire     (retire)
  );

  retire_checker retire_checker_inst (
    .clk         (clk),
    .reset       (reset),
    .inst        (inst),
    .test_name   (test_name),
    .retire      (retire),
    .current_pc  (current_pc),
    .next_pc     (next_pc),
    .halted      (halted),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // one lfsr step per bit
  task automatic rand_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
    return {funct7, rs2, rs1, 3'b000, rd, rv_isa_pkg::opcode_op};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, rv_isa_pkg::opcode_op_imm};
  endfunction

  function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  // foreign opcodes plus subset opcodes with funct fields outside the subset
  function automatic logic [31:0] unimpl_word(input logic [2:0] sel,
                                              input logic [24:0] bits);
    logic [31:0] word;
    word = {bits, 7'b0000000};
    case (sel)
      // load
      3'd0: word[6:0] = 7'b0000011;
      // store
      3'd1: word[6:0] = 7'b0100011;
      // branch
      3'd2: word[6:0] = 7'b1100011;
      // jal
      3'd3: word[6:0] = 7'b1101111;
      3'd4: begin
        word[6:0] = rv_isa_pkg::opcode_op;
        // odd funct7 is neither add nor sub
        word[25]  = 1'b1;
      end
      3'd5: begin
        word[6:0] = rv_isa_pkg::opcode_op_imm;
        // nonzero funct3 rules out addi
        word[12]  = 1'b1;
      end
      3'd6: begin
        word[6:0] = rv_isa_pkg::opcode_system;
        // csr space, never ebreak
        word[12]  = 1'b1;
      end
      // jalr
      default: word[6:0] = 7'b1100111;
    endcase
    return word;
  endfunction

  // present a word and hold it through one edge
  task automatic issue(input logic [31:0] word);
    inst = word;
    @(posedge clk);
    #2;
  endtask

  initial begin
    logic [31:0] sel;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    reset = 1'b1;
    inst = 32'h0000_0013;
    test_name = "reset_state";
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;
    // untouched registers so every sum is zero
    for (int i = 0; i < 4; i++) begin
      rand_bits(15, rs1);
      issue(encode_r(7'b0000000, rs1[14:10], rs1[9:5], rs1[4:0]));
    end
    // x0..x7 only so results get reused
    test_name = "imm_ops";
    for (int i = 0; i < 40; i++) begin
      rand_bits(2, sel);
      rand_bits(3, rd);
      rand_bits(3, rs1);
      rand_bits(20, imm);
      case (sel[1:0])
        2'd2: issue(encode_u(imm[19:0], rd[4:0], rv_isa_pkg::opcode_lui));
        2'd3: issue(encode_u(imm[19:0], rd[4:0], rv_isa_pkg::opcode_auipc));
        default: issue(encode_i(imm[11:0], rs1[4:0], rd[4:0]));
      endcase
    end
    test_name = "reg_ops";
    for (int i = 0; i < 40; i++) begin
      rand_bits(1, sel);
      rand_bits(3, rd);
      rand_bits(3, rs1);
      rand_bits(3, rs2);
      issue(encode_r(sel[0] ? rv_isa_pkg::funct7_sub : 7'b0000000,
                     rs2[4:0], rs1[4:0], rd[4:0]));
    end
    // every kind of bad word twice
    test_name = "not_impl";
    for (int i = 0; i < 16; i++) begin
      rand_bits(25, imm);
      issue(unimpl_word(3'(i), imm[24:0]));
    end
    // core must freeze after this
    test_name = "halt";
    issue(rv_isa_pkg::inst_ebreak);
    for (int i = 0; i < 6; i++) begin
      rand_bits(3, rd);
      rand_bits(12, imm);
      issue(encode_i(imm[11:0], 5'd1, rd[4:0]));
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog sized from the instruction count
  initial begin
    #((num_inst + reset_cycles + 20) * clk_period);
    $display("timeout: the test sequence did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu #(
  parameter int unsigned width = 32
) (
  input  core_pkg::alu_op_t  op,
  input  logic [width-1:0]   operand_a,
  input  logic [width-1:0]   operand_b,
  output logic [width-1:0]   result
);

  logic [width-1:0] sum;
  logic [width-1:0] diff;

  // both wrap at width bits, carry dropped
  assign sum  = operand_a + operand_b;
  assign diff = operand_a - operand_b;

  always_comb begin
    case (op)
      core_pkg::alu_add: begin
        result = sum;
      end
      core_pkg::alu_sub: begin
        result = diff;
      end
      core_pkg::alu_pass_b: begin
        // lui path
        result = operand_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* source/core_pkg.sv */
package core_pkg;

  // alu function select
  // encoding 2'b11 is unused
  typedef enum logic [1:0] {
    alu_add    = 2'b00,
    alu_sub    = 2'b01,
    alu_pass_b = 2'b10
  } alu_op_t;

  // decoder output, consumed in the same cycle
  typedef struct packed {
    logic [rv_isa_pkg::reg_id_width-1:0] rd;
    logic [rv_isa_pkg::reg_id_width-1:0] rs1;
    logic [rv_isa_pkg::reg_id_width-1:0] rs2;
    // already sign extended or shifted up
    logic [rv_isa_pkg::xlen-1:0]         imm;
    // operand b from imm instead of rs2
    logic                                use_imm;
    // operand a from pc instead of rs1
    logic                                use_pc;
    logic                                reg_write;
    logic                                is_ebreak;
    // encoding outside the subset
    logic                                not_impl;
    alu_op_t                             alu_op;
  } decode_t;

  // one record per executed instruction
  typedef struct packed {
    logic                                valid;
    logic [rv_isa_pkg::xlen-1:0]         pc;
    logic                                wen;
    logic [rv_isa_pkg::reg_id_width-1:0] rd;
    logic [rv_isa_pkg::xlen-1:0]         wdata;
    logic                                not_impl;
    logic                                is_ebreak;
  } retire_t;

endpackage

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic [rv_isa_pkg::inst_width-1:0] inst,
  output core_pkg::decode_t                 dec
);

  rv_isa_pkg::inst_fields_t       fields;
  logic [rv_isa_pkg::xlen-1:0]    imm_i;
  logic [rv_isa_pkg::xlen-1:0]    imm_u;

  assign fields = rv_isa_pkg::inst_fields_t'(inst);

  // i-type: bits 31:20, sign from bit 31
  assign imm_i = {{20{fields.funct7[6]}}, fields.funct7, fields.rs2};
  // u-type: upper 20 bits, low 12 zero
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    // register indices straight from the word
    dec.rd        = fields.rd;
    dec.rs1       = fields.rs1;
    dec.rs2       = fields.rs2;
    dec.imm       = imm_i;
    dec.use_imm   = 1'b0;
    dec.use_pc    = 1'b0;
    dec.reg_write = 1'b0;
    dec.is_ebreak = 1'b0;
    dec.not_impl  = 1'b0;
    dec.alu_op    = core_pkg::alu_add;

    case (fields.opcode)
      rv_isa_pkg::opcode_op: begin
        // add / sub, other funct combos rejected
        if (fields.funct3 == rv_isa_pkg::funct3_add &&
            fields.funct7 == rv_isa_pkg::funct7_add) begin
          dec.reg_write = 1'b1;
        end else if (fields.funct3 == rv_isa_pkg::funct3_add &&
                     fields.funct7 == rv_isa_pkg::funct7_sub) begin
          dec.reg_write = 1'b1;
          dec.alu_op    = core_pkg::alu_sub;
        end else begin
          dec.not_impl = 1'b1;
        end
      end
      rv_isa_pkg::opcode_op_imm: begin
        // addi only
        if (fields.funct3 == rv_isa_pkg::funct3_add) begin
          dec.use_imm   = 1'b1;
          dec.reg_write = 1'b1;
        end else begin
          dec.not_impl = 1'b1;
        end
      end
      rv_isa_pkg::opcode_lui: begin
        // immediate straight through
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.alu_op    = core_pkg::alu_pass_b;
      end
      rv_isa_pkg::opcode_auipc: begin
        // pc plus upper immediate
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.use_pc    = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_isa_pkg::opcode_system: begin
        // ebreak only, csr and ecall rejected
        if (inst == rv_isa_pkg::inst_ebreak) begin
          dec.is_ebreak = 1'b1;
        end else begin
          dec.not_impl = 1'b1;
        end
      end
      default: begin
        dec.not_impl = 1'b1;
      end
    endcase
  end

endmodule

/* source/pc_reg.sv */
`timescale 1ns/1ps

module pc_reg #(
  parameter int unsigned     xlen     = 32,
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            halt_req,
  output logic [xlen-1:0] current_pc,
  output logic [xlen-1:0] next_pc,
  output logic            halted
);

  // sequential flow only, no branches
  // hold in the halt cycle and after it
  always_comb begin
    if (halted || halt_req) begin
      next_pc = current_pc;
    end else begin
      next_pc = current_pc + xlen'(4);
    end
  end

  // pc and sticky halt flag
  always_ff @(posedge clk) begin
    if (reset) begin
      current_pc <= reset_pc;
      halted     <= 1'b0;
    end else begin
      current_pc <= next_pc;
      // only reset leaves halt
      halted     <= halted | halt_req;
    end
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file #(
  parameter int unsigned addr_width = 5,
  parameter int unsigned data_width = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wen,
  input  logic [addr_width-1:0] waddr,
  input  logic [data_width-1:0] wdata,
  input  logic [addr_width-1:0] raddr_1,
  input  logic [addr_width-1:0] raddr_2,
  output logic [data_width-1:0] rdata_1,
  output logic [data_width-1:0] rdata_2
);

  localparam int unsigned depth = 2 ** addr_width;

  logic [data_width-1:0] regs [depth];

  // single write port, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads
  // no bypass, write lands before next read cycle
  always_comb begin
    rdata_1 = regs[raddr_1];
    rdata_2 = regs[raddr_2];
    // x0 hard-wired
    if (raddr_1 == '0) begin
      rdata_1 = '0;
    end
    if (raddr_2 == '0) begin
      rdata_2 = '0;
    end
  end

endmodule

/* source/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
  parameter int unsigned     xlen     = rv_isa_pkg::xlen,
  parameter logic [xlen-1:0] reset_pc = rv_isa_pkg::reset_pc
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [rv_isa_pkg::inst_width-1:0] inst,
  output logic [xlen-1:0]                   current_pc,
  output logic [xlen-1:0]                   next_pc,
  output logic                              halted,
  output core_pkg::retire_t                 retire
);

  core_pkg::decode_t dec;
  logic [xlen-1:0]   rdata_1;
  logic [xlen-1:0]   rdata_2;
  logic [xlen-1:0]   operand_a;
  logic [xlen-1:0]   operand_b;
  logic [xlen-1:0]   result;
  logic              wen;
  logic              halt_req;

  // decode stage, purely combinational
  inst_decoder inst_decoder_inst (
    .inst (inst),
    .dec  (dec)
  );

  register_file #(
    .addr_width (rv_isa_pkg::reg_id_width),
    .data_width (xlen)
  ) register_file_inst (
    .clk     (clk),
    .reset   (reset),
    .wen     (wen),
    .waddr   (dec.rd),
    .wdata   (result),
    .raddr_1 (dec.rs1),
    .raddr_2 (dec.rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // operand a: pc for auipc
  assign operand_a = dec.use_pc ? current_pc : rdata_1;
  // operand b: immediate for addi, lui, auipc
  assign operand_b = dec.use_imm ? dec.imm : rdata_2;

  alu #(
    .width (xlen)
  ) alu_inst (
    .op        (dec.alu_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (result)
  );

  // no write-back once stopped
  assign wen      = dec.reg_write && !halted;
  // ebreak only counts before the first halt
  assign halt_req = dec.is_ebreak && !halted;

  pc_reg #(
    .xlen     (xlen),
    .reset_pc (reset_pc)
  ) pc_reg_inst (
    .clk        (clk),
    .reset      (reset),
    .halt_req   (halt_req),
    .current_pc (current_pc),
    .next_pc    (next_pc),
    .halted     (halted)
  );

  // retire record for this cycle's instruction
  always_comb begin
    retire.valid     = !halted;
    retire.pc        = current_pc;
    retire.wen       = wen;
    retire.rd        = dec.rd;
    retire.wdata     = result;
    retire.not_impl  = dec.not_impl;
    retire.is_ebreak = dec.is_ebreak;
  end

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

  // data path and address width
  localparam int unsigned xlen = 32;
  // architectural register index
  localparam int unsigned reg_id_width = 5;
  // fixed instruction word width
  localparam int unsigned inst_width = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes of the implemented subset
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // add / addi / sub share funct3 zero
  localparam logic [2:0] funct3_add = 3'b000;
  // funct7 picks add or sub within opcode_op
  localparam logic [6:0] funct7_add = 7'b0000000;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // ebreak is matched on the whole word
  localparam logic [inst_width-1:0] inst_ebreak = 32'h0010_0073;

  // r/i-type field layout, msb first
  // i-type immediate overlays funct7 and rs2
  typedef struct packed {
    logic [6:0]              funct7;
    logic [reg_id_width-1:0] rs2;
    logic [reg_id_width-1:0] rs1;
    logic [2:0]              funct3;
    logic [reg_id_width-1:0] rd;
    logic [6:0]              opcode;
  } inst_fields_t;

endpackage
